//--- ctrlUnit.f
+incdir+.
isaPkg.sv
ctrlPkg.sv
instrDecoder.sv
stateSequencer.sv
controlWordGen.sv
ctrlUnit.sv
ctrlChecker.sv
tbCtrlUnit.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbCtrlUnit -f ctrlUnit.f -o simCtrlUnit

out=$(./obj_dir/simCtrlUnit)
echo "$out"

echo "$out" | grep -qx "TESTS PASSED"

//--- tbCtrlUnit.sv
`timescale 1ns/1ps

module tbCtrlUnit;
    import isaPkg::*;
    import ctrlPkg::*;

    logic         clk;
    logic         rstN;
    logic         zero;
    instrFields_t fields;
    ctrlWord_t    ctrl;
    ctrlState_t   state;
    logic [31:0]  seed;
    int           checkCount;
    int           errorCount;
    int           timeouts;

    ctrlUnit dut0 (
        .clk    (clk),
        .rstN   (rstN),
        .fields (fields),
        .zero   (zero),
        .ctrl   (ctrl),
        .state  (state)
    );

    ctrlChecker checker0 (
        .clk        (clk),
        .rstN       (rstN),
        .fields     (fields),
        .zero       (zero),
        .ctrl       (ctrl),
        .state      (state),
        .checkCount (checkCount),
        .errorCount (errorCount)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Roughly one in eleven instructions is illegal
    function automatic instrFields_t pickFields(logic [31:0] r);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [31:0] sel;
        sel = r % 11;
        op  = r[13:8];
        fn  = r[21:16];
        case (sel)
            0: begin
                if (r[24]) begin
                    // Top bits 11 match no supported opcode
                    op = op | 6'b110000;
                end else begin
                    op = OP_RTYPE;
                    fn = fn | 6'b000001;
                end
            end
            1: begin
                op = OP_RTYPE;
                fn = FN_ADD;
            end
            2: begin
                op = OP_RTYPE;
                fn = FN_SUB;
            end
            3: begin
                op = OP_RTYPE;
                fn = FN_AND;
            end
            4: begin
                op = OP_RTYPE;
                fn = FN_SLT;
            end
            5:       op = OP_ADDI;
            6:       op = OP_BEQ;
            7:       op = OP_BNE;
            8:       op = OP_LW;
            9:       op = OP_SW;
            default: op = OP_J;
        endcase
        return instrFields_t'({op, fn});
    endfunction

    // Steps on falling edges, drawing zero each cycle
    task automatic waitFetch(input logic entering, output logic ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < 20 && !ok; n++) begin
            @(negedge clk);
            seed = xorshift(seed);
            zero = seed[0];
            ok   = ((state == S_FETCH_WAIT) == entering);
        end
        if (!ok) begin
            timeouts++;
            $display("Timeout: no FETCH_WAIT %s within 20 cycles at %0t",
                     entering ? "entry" : "exit", $time);
        end
    endtask

    initial begin
        int   i;
        logic ok;
        clk      = 1'b0;
        rstN     = 1'b0;
        zero     = 1'b0;
        fields   = instrFields_t'(12'h0);
        seed     = 32'h6f77;
        timeouts = 0;
        repeat (10) @(negedge clk);
        rstN = 1'b1;
        ok   = 1'b1;
        for (i = 0; i < 400 && ok; i++) begin
            waitFetch(1'b1, ok);
            if (ok) begin
                // Held until the next fetch, like the instruction register
                seed   = xorshift(seed);
                fields = pickFields(seed);
                waitFetch(1'b0, ok);
            end
        end
        if (ok) begin
            waitFetch(1'b1, ok);
        end
        @(negedge clk);
        $display("Summary: %0d checks, %0d mismatches, %0d timeouts",
                 checkCount, errorCount, timeouts);
        if (ok && errorCount == 0 && checkCount > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- ctrlChecker.sv
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module ctrlChecker (
    input  logic                 clk,
    input  logic                 rstN,
    input  isaPkg::instrFields_t fields,
    input  logic                 zero,
    input  ctrlPkg::ctrlWord_t   ctrl,
    input  ctrlPkg::ctrlState_t  state,
    output int                   checkCount,
    output int                   errorCount
);
    import isaPkg::*;
    import ctrlPkg::*;

    ctrlState_t  mState;
    ctrlState_t  prevState;
    instrClass_t mCls;
    aluOp_t      mFn;
    int          mWait;
    int          cycles;

    function automatic instrClass_t classOf(instrFields_t f);
        case (f.opcode)
            OP_RTYPE: begin
                if (f.funct inside {FN_ADD, FN_SUB, FN_AND, FN_SLT}) begin
                    return CLS_ALU_R;
                end
                return CLS_ILLEGAL;
            end
            OP_ADDI: return CLS_ALU_IMM;
            OP_BEQ:  return CLS_BRANCH_EQ;
            OP_BNE:  return CLS_BRANCH_NE;
            OP_LW:   return CLS_LOAD;
            OP_SW:   return CLS_STORE;
            OP_J:    return CLS_JUMP;
            default: return CLS_ILLEGAL;
        endcase
    endfunction

    function automatic aluOp_t opOf(funct_t fn);
        case (fn)
            FN_SUB:  return ALU_SUB;
            FN_AND:  return ALU_AND;
            FN_SLT:  return ALU_SLT;
            default: return ALU_ADD;
        endcase
    endfunction

    // Fetch, latch and decode, then the class specific tail
    function automatic int latencyOf(instrClass_t c);
        int fetch;
        fetch = `MEM_WAIT_CYCLES + 2;
        case (c)
            CLS_ALU_R, CLS_ALU_IMM, CLS_STORE: return fetch + 2;
            CLS_LOAD: return fetch + `MEM_WAIT_CYCLES + 3;
            default:  return fetch + 1;
        endcase
    endfunction

    function automatic ctrlState_t nextState(ctrlState_t s, instrClass_t c, logic done);
        case (s)
            S_FETCH_WAIT:  return done ? S_FETCH_LATCH : S_FETCH_WAIT;
            S_FETCH_LATCH: return S_DECODE;
            S_DECODE: begin
                if (c inside {CLS_ALU_R, CLS_ALU_IMM}) begin
                    return S_EXECUTE;
                end
                if (c inside {CLS_BRANCH_EQ, CLS_BRANCH_NE}) begin
                    return S_BRANCH;
                end
                if (c inside {CLS_LOAD, CLS_STORE}) begin
                    return S_ADDR_CALC;
                end
                return (c == CLS_JUMP) ? S_JUMP : S_TRAP;
            end
            S_EXECUTE:        return S_WRITE_BACK;
            S_ADDR_CALC:      return (c == CLS_LOAD) ? S_MEM_READ_WAIT : S_MEM_WRITE;
            S_MEM_READ_WAIT:  return done ? S_MEM_READ_LATCH : S_MEM_READ_WAIT;
            S_MEM_READ_LATCH: return S_LOAD_WRITE;
            default:          return S_FETCH_WAIT;
        endcase
    endfunction

    // Built field by field from the control word table
    function automatic ctrlWord_t expWord(ctrlState_t s, instrClass_t c, aluOp_t fn, logic z);
        ctrlWord_t w;
        w = '0;
        w.memRead     = s inside {S_FETCH_WAIT, S_FETCH_LATCH,
                                  S_MEM_READ_WAIT, S_MEM_READ_LATCH};
        w.memWrite    = (s == S_MEM_WRITE);
        w.irWrite     = (s == S_FETCH_LATCH);
        w.regLoad     = (s == S_DECODE);
        w.aluOutWrite = s inside {S_DECODE, S_EXECUTE, S_ADDR_CALC};
        w.mdrWrite    = (s == S_MEM_READ_LATCH);
        w.regWrite    = s inside {S_WRITE_BACK, S_LOAD_WRITE};
        w.epcWrite    = (s == S_TRAP);
        w.pcWrite     = s inside {S_FETCH_LATCH, S_JUMP, S_TRAP};
        // beq taken on zero, bne on nonzero
        if (s == S_BRANCH) begin
            w.pcWrite = (c == CLS_BRANCH_EQ) ? z : !z;
        end
        if (s inside {S_MEM_READ_WAIT, S_MEM_READ_LATCH, S_MEM_WRITE}) begin
            w.iorD = ADDR_ALU_OUT;
        end
        if (s inside {S_EXECUTE, S_BRANCH, S_ADDR_CALC}) begin
            w.aluSrcA = SRCA_REG_A;
        end
        case (s)
            S_FETCH_LATCH: w.aluSrcB = SRCB_FOUR;
            S_DECODE:      w.aluSrcB = SRCB_IMM_SHIFTED;
            S_EXECUTE:     w.aluSrcB = (c == CLS_ALU_R) ? SRCB_REG_B : SRCB_IMM;
            S_ADDR_CALC:   w.aluSrcB = SRCB_IMM;
            default:       w.aluSrcB = SRCB_REG_B;
        endcase
        if (s == S_BRANCH) begin
            w.aluOp = ALU_SUB;
        end else if (s == S_EXECUTE && c == CLS_ALU_R) begin
            w.aluOp = fn;
        end
        case (s)
            S_BRANCH: w.pcSource = PCSRC_ALU_OUT;
            S_JUMP:   w.pcSource = PCSRC_JUMP_TARGET;
            S_TRAP:   w.pcSource = PCSRC_EXC_VECTOR;
            default:  w.pcSource = PCSRC_ALU_RESULT;
        endcase
        if (s == S_WRITE_BACK && c == CLS_ALU_R) begin
            w.regDst = DST_RD;
        end
        if (s == S_LOAD_WRITE) begin
            w.regData = DATA_MDR;
        end
        return w;
    endfunction

    always @(posedge clk) begin
        instrClass_t cls;
        aluOp_t      fn;
        ctrlWord_t   expCtrl;
        logic        done;
        if (!rstN) begin
            mState     <= S_FETCH_WAIT;
            prevState  <= S_FETCH_WAIT;
            mCls       <= CLS_ILLEGAL;
            mFn        <= ALU_ADD;
            mWait      <= 0;
            cycles     <= 0;
            checkCount = 0;
            errorCount = 0;
        end else begin
            // Fresh decode only in the decode cycle
            cls     = (mState == S_DECODE) ? classOf(fields) : mCls;
            fn      = (mState == S_DECODE) ? opOf(fields.funct) : mFn;
            expCtrl = expWord(mState, cls, fn, zero);
            checkCount = checkCount + 1;
            if (state !== mState) begin
                errorCount = errorCount + 1;
                $display("[FAIL] %0t: state is %s, expected %s",
                         $time, state.name(), mState.name());
            end
            if (ctrl !== expCtrl) begin
                errorCount = errorCount + 1;
                $display("[FAIL] %0t: ctrl in %s is %p, expected %p",
                         $time, mState.name(), ctrl, expCtrl);
            end
            // Instruction boundary seen on the DUT state
            if (state == S_FETCH_WAIT && prevState != S_FETCH_WAIT) begin
                if (cycles != latencyOf(mCls)) begin
                    errorCount = errorCount + 1;
                    $display("[FAIL] %0t: latency of %s is %0d, expected %0d",
                             $time, mCls.name(), cycles, latencyOf(mCls));
                end
                cycles <= 1;
            end else begin
                cycles <= cycles + 1;
            end
            prevState <= state;
            done      = (mWait == `MEM_WAIT_CYCLES - 1);
            mState    <= nextState(mState, cls, done);
            if (mState inside {S_FETCH_WAIT, S_MEM_READ_WAIT} && !done) begin
                mWait <= mWait + 1;
            end else begin
                mWait <= 0;
            end
            if (mState == S_DECODE) begin
                mCls <= cls;
                mFn  <= fn;
            end
        end
    end

endmodule

//--- ctrlUnit.sv
`timescale 1ns/1ps

module ctrlUnit (
    input  logic                 clk,
    input  logic                 rstN,
    input  isaPkg::instrFields_t fields,
    input  logic                 zero,
    output ctrlPkg::ctrlWord_t   ctrl,
    output ctrlPkg::ctrlState_t  state
);
    import isaPkg::*;
    import ctrlPkg::*;

    instrClass_t instrClass;
    aluOp_t      aluFunct;

    instrDecoder decoder0 (
        .clk        (clk),
        .rstN       (rstN),
        .state      (state),
        .fields     (fields),
        .instrClass (instrClass),
        .aluFunct   (aluFunct)
    );

    stateSequencer sequencer0 (
        .clk        (clk),
        .rstN       (rstN),
        .instrClass (instrClass),
        .state      (state)
    );

    // Control word is purely a function of the current cycle
    controlWordGen wordGen0 (
        .state      (state),
        .instrClass (instrClass),
        .aluFunct   (aluFunct),
        .zero       (zero),
        .ctrl       (ctrl)
    );

endmodule

//--- controlWordGen.sv
`timescale 1ns/1ps

module controlWordGen (
    input  ctrlPkg::ctrlState_t state,
    input  isaPkg::instrClass_t instrClass,
    input  ctrlPkg::aluOp_t     aluFunct,
    input  logic                zero,
    output ctrlPkg::ctrlWord_t  ctrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    always_comb begin
        // All enables off, selects at their first value
        ctrl = '0;
        case (state)
            S_FETCH_WAIT: begin
                ctrl.memRead = 1'b1;
                ctrl.iorD    = ADDR_PC;
            end
            S_FETCH_LATCH: begin
                ctrl.memRead  = 1'b1;
                ctrl.irWrite  = 1'b1;
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSource = PCSRC_ALU_RESULT;
                ctrl.aluSrcA  = SRCA_PC;
                ctrl.aluSrcB  = SRCB_FOUR;
                ctrl.aluOp    = ALU_ADD;
            end
            S_DECODE: begin
                // Branch target computed early
                ctrl.regLoad     = 1'b1;
                ctrl.aluOutWrite = 1'b1;
                ctrl.aluSrcA     = SRCA_PC;
                ctrl.aluSrcB     = SRCB_IMM_SHIFTED;
                ctrl.aluOp       = ALU_ADD;
            end
            S_EXECUTE: begin
                ctrl.aluOutWrite = 1'b1;
                ctrl.aluSrcA     = SRCA_REG_A;
                if (instrClass == CLS_ALU_R) begin
                    ctrl.aluSrcB = SRCB_REG_B;
                    ctrl.aluOp   = aluFunct;
                end else begin
                    ctrl.aluSrcB = SRCB_IMM;
                    ctrl.aluOp   = ALU_ADD;
                end
            end
            S_WRITE_BACK: begin
                ctrl.regWrite = 1'b1;
                ctrl.regData  = DATA_ALU_OUT;
                ctrl.regDst   = (instrClass == CLS_ALU_R) ? DST_RD : DST_RT;
            end
            S_BRANCH: begin
                ctrl.aluSrcA  = SRCA_REG_A;
                ctrl.aluSrcB  = SRCB_REG_B;
                ctrl.aluOp    = ALU_SUB;
                ctrl.pcSource = PCSRC_ALU_OUT;
                ctrl.pcWrite  = (instrClass == CLS_BRANCH_EQ) ? zero : !zero;
            end
            S_JUMP: begin
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSource = PCSRC_JUMP_TARGET;
            end
            S_ADDR_CALC: begin
                ctrl.aluOutWrite = 1'b1;
                ctrl.aluSrcA     = SRCA_REG_A;
                ctrl.aluSrcB     = SRCB_IMM;
                ctrl.aluOp       = ALU_ADD;
            end
            S_MEM_READ_WAIT: begin
                ctrl.memRead = 1'b1;
                ctrl.iorD    = ADDR_ALU_OUT;
            end
            S_MEM_READ_LATCH: begin
                ctrl.memRead  = 1'b1;
                ctrl.iorD     = ADDR_ALU_OUT;
                ctrl.mdrWrite = 1'b1;
            end
            S_LOAD_WRITE: begin
                ctrl.regWrite = 1'b1;
                ctrl.regData  = DATA_MDR;
                ctrl.regDst   = DST_RT;
            end
            S_MEM_WRITE: begin
                ctrl.memWrite = 1'b1;
                ctrl.iorD     = ADDR_ALU_OUT;
            end
            S_TRAP: begin
                ctrl.epcWrite = 1'b1;
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSource = PCSRC_EXC_VECTOR;
            end
            default: ctrl = '0;
        endcase
    end

    // Single memory port
    always_comb begin
        assert (!(ctrl.memRead && ctrl.memWrite))
            else $error("read and write requested together");
        assert (!ctrl.irWrite || ctrl.pcWrite)
            else $error("instruction latched without PC advance");
    end

endmodule

//--- stateSequencer.sv
`timescale 1ns/1ps
`include "ctrl_defines.svh"

module stateSequencer (
    input  logic                clk,
    input  logic                rstN,
    input  isaPkg::instrClass_t instrClass,
    output ctrlPkg::ctrlState_t state
);
    import isaPkg::*;
    import ctrlPkg::*;

    localparam int CntW = $clog2(`MEM_WAIT_CYCLES + 1);

    ctrlState_t      stateNext;
    logic [CntW-1:0] waitCnt;
    logic [CntW-1:0] waitNext;
    logic            waitDone;
    logic            waiting;

    assign waiting  = (state == S_FETCH_WAIT) || (state == S_MEM_READ_WAIT);
    assign waitDone = (waitCnt == CntW'(`MEM_WAIT_CYCLES - 1));

    // Counter only runs in the two memory wait states
    always_comb begin
        if (waiting && !waitDone) begin
            waitNext = waitCnt + 1'b1;
        end else begin
            waitNext = '0;
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            S_FETCH_WAIT: begin
                if (waitDone) begin
                    stateNext = S_FETCH_LATCH;
                end
            end
            S_FETCH_LATCH: stateNext = S_DECODE;
            S_DECODE: begin
                case (instrClass)
                    CLS_ALU_R, CLS_ALU_IMM:         stateNext = S_EXECUTE;
                    CLS_BRANCH_EQ, CLS_BRANCH_NE:   stateNext = S_BRANCH;
                    CLS_LOAD, CLS_STORE:            stateNext = S_ADDR_CALC;
                    CLS_JUMP:                       stateNext = S_JUMP;
                    default:                        stateNext = S_TRAP;
                endcase
            end
            S_EXECUTE: stateNext = S_WRITE_BACK;
            S_ADDR_CALC: begin
                if (instrClass == CLS_LOAD) begin
                    stateNext = S_MEM_READ_WAIT;
                end else begin
                    stateNext = S_MEM_WRITE;
                end
            end
            S_MEM_READ_WAIT: begin
                if (waitDone) begin
                    stateNext = S_MEM_READ_LATCH;
                end
            end
            S_MEM_READ_LATCH: stateNext = S_LOAD_WRITE;
            // Last state of every sequence
            default: stateNext = S_FETCH_WAIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= S_FETCH_WAIT;
            waitCnt <= '0;
        end else begin
            state   <= stateNext;
            waitCnt <= waitNext;
        end
    end

    waitBound: assert property (@(posedge clk) disable iff (!rstN)
        int'(waitCnt) < `MEM_WAIT_CYCLES)
        else $error("wait counter overran");

    legalState: assert property (@(posedge clk) disable iff (!rstN)
        state inside {[S_FETCH_WAIT:S_TRAP]})
        else $error("state register holds an unused code");

endmodule

//--- instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  logic                clk,
    input  logic                rstN,
    input  ctrlPkg::ctrlState_t state,
    input  isaPkg::instrFields_t fields,
    output isaPkg::instrClass_t instrClass,
    output ctrlPkg::aluOp_t     aluFunct
);
    import isaPkg::*;
    import ctrlPkg::*;

    instrClass_t classD;
    instrClass_t classQ;
    aluOp_t      functD;
    aluOp_t      functQ;

    always_comb begin
        classD = CLS_ILLEGAL;
        functD = ALU_ADD;
        case (fields.opcode)
            OP_RTYPE: begin
                classD = CLS_ALU_R;
                case (fields.funct)
                    FN_ADD:  functD = ALU_ADD;
                    FN_SUB:  functD = ALU_SUB;
                    FN_AND:  functD = ALU_AND;
                    FN_SLT:  functD = ALU_SLT;
                    // Unknown funct traps like a bad opcode
                    default: classD = CLS_ILLEGAL;
                endcase
            end
            OP_ADDI: classD = CLS_ALU_IMM;
            OP_BEQ:  classD = CLS_BRANCH_EQ;
            OP_BNE:  classD = CLS_BRANCH_NE;
            OP_LW:   classD = CLS_LOAD;
            OP_SW:   classD = CLS_STORE;
            OP_J:    classD = CLS_JUMP;
            default: classD = CLS_ILLEGAL;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            classQ <= CLS_ILLEGAL;
        end else if (state == S_DECODE) begin
            classQ <= classD;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_DECODE) begin
            functQ <= functD;
        end
    end

    // Sequencer branches on the fresh class during decode
    assign instrClass = (state == S_DECODE) ? classD : classQ;
    assign aluFunct   = (state == S_DECODE) ? functD : functQ;

    // Class is held for the whole instruction
    classHeld: assert property (@(posedge clk) disable iff (!rstN)
        ($past(rstN) && $past(state) != S_DECODE) |-> classQ == $past(classQ))
        else $error("decoded class changed outside decode");

endmodule

//--- ctrlPkg.sv
package ctrlPkg;

    typedef enum logic [3:0] {
        S_FETCH_WAIT,
        S_FETCH_LATCH,
        S_DECODE,
        S_EXECUTE,
        S_WRITE_BACK,
        S_BRANCH,
        S_JUMP,
        S_ADDR_CALC,
        S_MEM_READ_WAIT,
        S_MEM_READ_LATCH,
        S_MEM_WRITE,
        S_LOAD_WRITE,
        S_TRAP
    } ctrlState_t;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_SLT} aluOp_t;

    // Memory address source
    typedef enum logic {ADDR_PC, ADDR_ALU_OUT} addrSrc_t;

    typedef enum logic {SRCA_PC, SRCA_REG_A} aluSrcA_t;

    typedef enum logic [1:0] {
        SRCB_REG_B,
        SRCB_FOUR,
        SRCB_IMM,
        SRCB_IMM_SHIFTED
    } aluSrcB_t;

    typedef enum logic [1:0] {
        PCSRC_ALU_RESULT,
        PCSRC_ALU_OUT,
        PCSRC_JUMP_TARGET,
        PCSRC_EXC_VECTOR
    } pcSource_t;

    typedef enum logic {DST_RT, DST_RD} regDst_t;

    typedef enum logic {DATA_ALU_OUT, DATA_MDR} regData_t;

    // Everything the datapath needs in one cycle
    typedef struct packed {
        logic      pcWrite;
        logic      memRead;
        logic      memWrite;
        logic      irWrite;
        logic      regLoad;
        logic      aluOutWrite;
        logic      mdrWrite;
        logic      regWrite;
        logic      epcWrite;
        addrSrc_t  iorD;
        aluSrcA_t  aluSrcA;
        aluSrcB_t  aluSrcB;
        aluOp_t    aluOp;
        pcSource_t pcSource;
        regDst_t   regDst;
        regData_t  regData;
    } ctrlWord_t;

endpackage

//--- isaPkg.sv
`include "ctrl_defines.svh"

package isaPkg;

    // Supported primary opcodes
    typedef enum logic [`OPCODE_W-1:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDI  = 6'b001000,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcode_t;

    // R-type function codes
    typedef enum logic [`FUNCT_W-1:0] {
        FN_ADD = 6'b100000,
        FN_SUB = 6'b100010,
        FN_AND = 6'b100100,
        FN_SLT = 6'b101010
    } funct_t;

    typedef struct packed {
        opcode_t opcode;
        funct_t  funct;
    } instrFields_t;

    // What the sequencer and control word care about
    typedef enum logic [2:0] {
        CLS_ALU_R,
        CLS_ALU_IMM,
        CLS_BRANCH_EQ,
        CLS_BRANCH_NE,
        CLS_LOAD,
        CLS_STORE,
        CLS_JUMP,
        CLS_ILLEGAL
    } instrClass_t;

endpackage

//--- ctrl_defines.svh
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// Cycles until memory read data is valid
`define MEM_WAIT_CYCLES 3

// Instruction field widths
`define OPCODE_W 6
`define FUNCT_W 6

`endif
